// ==== src/opl_pkg.sv ====
// ---------------------------------------------------------
// opl timer package
// register indices, timer states and bit positions shared by
// the host port, the register bank and the interval timers
// ---------------------------------------------------------
`default_nettype none

package opl_pkg;

  // ---------------------------------------------------------
  // widths and types
  // ---------------------------------------------------------
  localparam int DATA_W = 8;

  // host data byte, also used for the register index
  typedef logic [DATA_W-1:0] data_t;

  // register indices decoded by the bank, all others ignored
  typedef enum logic [DATA_W-1:0] {
    REG_TIMER1_PRESET = 8'h02,
    REG_TIMER2_PRESET = 8'h03,
    REG_TIMER_CTRL    = 8'h04
  } opl_reg_e;

  typedef enum logic {
    TIMER_IDLE = 1'b0,
    TIMER_RUN  = 1'b1
  } timer_state_e;

  // ---------------------------------------------------------
  // control byte, register 4
  // ---------------------------------------------------------
  localparam int CTRL_CLEAR_BIT    = 7;
  localparam int CTRL_T1_MASK_BIT  = 6;
  localparam int CTRL_T2_MASK_BIT  = 5;
  localparam int CTRL_T2_START_BIT = 1;
  localparam int CTRL_T1_START_BIT = 0;

  // ---------------------------------------------------------
  // status byte, read with a0 low
  // ---------------------------------------------------------
  localparam int STAT_IRQ_BIT = 7;
  localparam int STAT_T1_BIT  = 6;
  localparam int STAT_T2_BIT  = 5;

endpackage

`default_nettype wire

// ==== src/opl_reg_if.sv ====
// ---------------------------------------------------------
// register interface between the host port and the timer
// register bank
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface opl_reg_if
  import opl_pkg::*;
();

  // one-cycle write strobe, index and data valid with it
  logic  wr;
  data_t index;
  data_t data;

  // overflow flags back to the status byte
  logic  t1_flag;
  logic  t2_flag;

  modport port (
    output wr,
    output index,
    output data,
    input  t1_flag,
    input  t2_flag
  );

  modport bank (
    input  wr,
    input  index,
    input  data,
    output t1_flag,
    output t2_flag
  );

endinterface

`default_nettype wire

// ==== src/opl_bus_port.sv ====
// ---------------------------------------------------------
// host bus port
// latches the register index, registers data writes and
// returns the status byte on a read with a0 low
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_bus_port
  import opl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cs_n,
  input  logic      wr_n,
  input  logic      a0,
  input  data_t     din,
  output data_t     dout,
  opl_reg_if.port   regs
);

  logic  host_wr;
  data_t index_q;
  logic  wr_q;
  data_t data_q;
  data_t status;

  // selected write cycle, a0 picks index or data
  assign host_wr = !cs_n && !wr_n;

  // ---------------------------------------------------------
  // index latch
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      index_q <= '0;
    end else if (host_wr && !a0) begin
      index_q <= din;
    end
  end

  // ---------------------------------------------------------
  // data write, strobe and byte registered together
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= host_wr && a0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_q <= '0;
    end else if (host_wr && a0) begin
      data_q <= din;
    end
  end

  assign regs.wr    = wr_q;
  assign regs.index = index_q;
  assign regs.data  = data_q;

  // ---------------------------------------------------------
  // status read
  // ---------------------------------------------------------
  // irq bit ignores the masks, as on the real chip
  always_comb begin
    status               = '0;
    status[STAT_IRQ_BIT] = regs.t1_flag | regs.t2_flag;
    status[STAT_T1_BIT]  = regs.t1_flag;
    status[STAT_T2_BIT]  = regs.t2_flag;
  end

  // a0 high reads return zero
  assign dout = (!cs_n && !a0) ? status : '0;

endmodule

`default_nettype wire

// ==== src/opl_timer_regs.sv ====
// ---------------------------------------------------------
// timer register bank
// presets, masks and start bits, overflow flags and irq_n
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_timer_regs
  import opl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  opl_reg_if.bank   regs,
  output data_t     t1_preset,
  output data_t     t2_preset,
  output logic      t1_start,
  output logic      t2_start,
  input  logic      t1_overflow,
  input  logic      t2_overflow,
  output logic      irq_n
);

  logic t1_preset_we;
  logic t2_preset_we;
  logic ctrl_we;
  logic clear_cmd;
  logic t1_mask;
  logic t2_mask;
  logic t1_flag;
  logic t2_flag;
  logic irq_set;

  // ---------------------------------------------------------
  // index decode
  // ---------------------------------------------------------
  always_comb begin
    t1_preset_we = 1'b0;
    t2_preset_we = 1'b0;
    ctrl_we      = 1'b0;
    if (regs.wr) begin
      case (regs.index)
        REG_TIMER1_PRESET: t1_preset_we = 1'b1;
        REG_TIMER2_PRESET: t2_preset_we = 1'b1;
        REG_TIMER_CTRL:    ctrl_we      = 1'b1;
        default:           ;
      endcase
    end
  end

  // clear write leaves masks and start bits alone
  assign clear_cmd = ctrl_we && regs.data[CTRL_CLEAR_BIT];

  // ---------------------------------------------------------
  // presets and control
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t1_preset <= '0;
      t2_preset <= '0;
    end else begin
      if (t1_preset_we) begin
        t1_preset <= regs.data;
      end
      if (t2_preset_we) begin
        t2_preset <= regs.data;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t1_mask  <= 1'b0;
      t2_mask  <= 1'b0;
      t1_start <= 1'b0;
      t2_start <= 1'b0;
    end else if (ctrl_we && !regs.data[CTRL_CLEAR_BIT]) begin
      t1_mask  <= regs.data[CTRL_T1_MASK_BIT];
      t2_mask  <= regs.data[CTRL_T2_MASK_BIT];
      t1_start <= regs.data[CTRL_T1_START_BIT];
      t2_start <= regs.data[CTRL_T2_START_BIT];
    end
  end

  // ---------------------------------------------------------
  // flags and interrupt
  // ---------------------------------------------------------
  // an overflow pulse beats a clear in the same cycle
  assign irq_set = (t1_overflow && !t1_mask) || (t2_overflow && !t2_mask);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      t1_flag <= 1'b0;
      t2_flag <= 1'b0;
      irq_n   <= 1'b1;
    end else begin
      if (t1_overflow) begin
        t1_flag <= 1'b1;
      end else if (clear_cmd) begin
        t1_flag <= 1'b0;
      end
      if (t2_overflow) begin
        t2_flag <= 1'b1;
      end else if (clear_cmd) begin
        t2_flag <= 1'b0;
      end
      if (irq_set) begin
        irq_n <= 1'b0;
      end else if (clear_cmd) begin
        irq_n <= 1'b1;
      end
    end
  end

  assign regs.t1_flag = t1_flag;
  assign regs.t2_flag = t2_flag;

endmodule

`default_nettype wire

// ==== src/opl_interval_timer.sv ====
// ---------------------------------------------------------
// interval timer
// tick prescaler and 8-bit up counter, one pulse per wrap
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_interval_timer
  import opl_pkg::*;
#(
  parameter int TICK_CYCLES = 3
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  data_t preset,
  output logic  overflow
);

  // prescaler counts TICK_CYCLES down to zero, TICK_CYCLES + 1 cycles per tick
  localparam int PRESCALE_W = (TICK_CYCLES > 0) ? $clog2(TICK_CYCLES + 1) : 1;
  localparam logic [PRESCALE_W-1:0] TICK_RELOAD = PRESCALE_W'(TICK_CYCLES);

  timer_state_e            state;
  logic [PRESCALE_W-1:0]   prescale;
  data_t                   count;
  logic                    load;
  logic                    tick;
  logic                    wrap;

  // idle with start high means start has just risen,
  // run is left as soon as start drops
  assign load = (state == TIMER_IDLE) && start;
  assign tick = (state == TIMER_RUN) && start && (prescale == '0);
  assign wrap = tick && (&count);

  // ---------------------------------------------------------
  // state
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= TIMER_IDLE;
    end else if (load) begin
      state <= TIMER_RUN;
    end else if (!start) begin
      state <= TIMER_IDLE;
    end
  end

  // ---------------------------------------------------------
  // prescaler and counter
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prescale <= '0;
    end else if (load || tick) begin
      prescale <= TICK_RELOAD;
    end else if (state == TIMER_RUN && start) begin
      prescale <= prescale - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (load || wrap) begin
      // preset is taken again on every wrap
      count <= preset;
    end else if (tick) begin
      count <= count + 1'b1;
    end
  end

  // one-cycle pulse after the wrap from 255
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      overflow <= 1'b0;
    end else begin
      overflow <= wrap;
    end
  end

endmodule

`default_nettype wire

// ==== src/opl_timers.sv ====
// ---------------------------------------------------------
// fm chip timer block, top level
// host port, timer register bank and two interval timers
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_timers
  import opl_pkg::*;
#(
  // 80 us and 320 us ticks at 50 MHz
  parameter int T1_TICK_CYCLES = 3999,
  parameter int T2_TICK_CYCLES = 15999
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  cs_n,
  input  logic  wr_n,
  input  logic  a0,
  input  data_t din,
  output data_t dout,
  output logic  irq_n
);

  data_t t1_preset;
  data_t t2_preset;
  logic  t1_start;
  logic  t2_start;
  logic  t1_overflow;
  logic  t2_overflow;

  opl_reg_if regs_if ();

  // ---------------------------------------------------------
  // host side
  // ---------------------------------------------------------
  opl_bus_port bus_port_inst (
    .clk  (clk),
    .rst  (rst),
    .cs_n (cs_n),
    .wr_n (wr_n),
    .a0   (a0),
    .din  (din),
    .dout (dout),
    .regs (regs_if.port)
  );

  opl_timer_regs timer_regs_inst (
    .clk         (clk),
    .rst         (rst),
    .regs        (regs_if.bank),
    .t1_preset   (t1_preset),
    .t2_preset   (t2_preset),
    .t1_start    (t1_start),
    .t2_start    (t2_start),
    .t1_overflow (t1_overflow),
    .t2_overflow (t2_overflow),
    .irq_n       (irq_n)
  );

  // ---------------------------------------------------------
  // timers
  // ---------------------------------------------------------
  opl_interval_timer #(
    .TICK_CYCLES (T1_TICK_CYCLES)
  ) t1_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (t1_start),
    .preset   (t1_preset),
    .overflow (t1_overflow)
  );

  opl_interval_timer #(
    .TICK_CYCLES (T2_TICK_CYCLES)
  ) t2_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (t2_start),
    .preset   (t2_preset),
    .overflow (t2_overflow)
  );

endmodule

`default_nettype wire

// ==== verification/opl_timers_assert.sv ====
// ---------------------------------------------------------
// timer register bank assertions
// flag, clear and interrupt rules checked on every clock
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_timers_assert (
  input logic clk,
  input logic rst,
  input logic clear_cmd,
  input logic t1_overflow,
  input logic t2_overflow,
  input logic t1_mask,
  input logic t2_mask,
  input logic t1_flag,
  input logic t2_flag,
  input logic irq_n
);

  // interrupt only with a flag behind it
  irq_needs_flag: assert property (
    @(posedge clk) disable iff (rst)
    !irq_n |-> (t1_flag || t2_flag)
  ) else $error("irq_n low while both overflow flags are clear");

  // clear with no competing pulse empties both flags
  clear_empties_flags: assert property (
    @(posedge clk) disable iff (rst)
    (clear_cmd && !t1_overflow && !t2_overflow) |=> (!t1_flag && !t2_flag)
  ) else $error("overflow flag still set one cycle after a clear write");

  // unmasked pulse pulls the interrupt low
  overflow_raises_irq: assert property (
    @(posedge clk) disable iff (rst)
    ((t1_overflow && !t1_mask) || (t2_overflow && !t2_mask)) |=> !irq_n
  ) else $error("irq_n not low one cycle after an unmasked overflow");

endmodule

bind opl_timer_regs opl_timers_assert timers_assert_inst (
  .clk         (clk),
  .rst         (rst),
  .clear_cmd   (clear_cmd),
  .t1_overflow (t1_overflow),
  .t2_overflow (t2_overflow),
  .t1_mask     (t1_mask),
  .t2_mask     (t2_mask),
  .t1_flag     (t1_flag),
  .t2_flag     (t2_flag),
  .irq_n       (irq_n)
);

`default_nettype wire

// ==== verification/opl_timers_tb.sv ====
// ---------------------------------------------------------
// opl timer block testbench
// host writes and status reads over the chip port
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module opl_timers_tb
  import opl_pkg::*;
();

  localparam int T1_TICK = 3;
  localparam int T2_TICK = 7;

  // top preset nibble forced high, so at most 16 ticks per period
  localparam int T1_MAX_PERIOD = 16 * (T1_TICK + 1);
  localparam int T2_MAX_PERIOD = 16 * (T2_TICK + 1);
  localparam int WAIT_SUM       = 2 * T1_MAX_PERIOD + 3 * T2_MAX_PERIOD;
  localparam int TIMEOUT_CYCLES = 2 * WAIT_SUM + 200;

  // irq bit with the timer 1 or timer 2 flag
  localparam data_t STAT_T1 = 8'hc0;
  localparam data_t STAT_T2 = 8'ha0;

  logic        clk;
  logic        rst;
  logic        cs_n;
  logic        wr_n;
  logic        a0;
  data_t       din;
  data_t       dout;
  logic        irq_n;
  logic [31:0] lfsr_state;
  int          cycle_count;

  opl_timers #(
    .T1_TICK_CYCLES (T1_TICK),
    .T2_TICK_CYCLES (T2_TICK)
  ) opl_timers_inst (
    .clk   (clk),
    .rst   (rst),
    .cs_n  (cs_n),
    .wr_n  (wr_n),
    .a0    (a0),
    .din   (din),
    .dout  (dout),
    .irq_n (irq_n)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ---------------------------------------------------------
  // helpers
  // ---------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    // x^32 + x^22 + x^2 + x + 1, right shifting
    lfsr_next = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function automatic int timer_period(input data_t preset, input int tick_cycles);
    timer_period = (256 - int'(preset)) * (tick_cycles + 1);
  endfunction

  task automatic draw_preset(output data_t value);
    value = 8'hf0;
    for (int i = 0; i < 4; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task report_mismatch(input string name, input data_t expected, input data_t actual);
    $display("ERR %s expected 0x%02h actual 0x%02h", name, expected, actual);
    stop_with_failure();
  endtask

  // index phase with a0 low, then data phase with a0 high
  task host_write(input data_t index, input data_t value);
    @(posedge clk);
    cs_n <= 1'b0;
    wr_n <= 1'b0;
    a0   <= 1'b0;
    din  <= index;
    @(posedge clk);
    a0   <= 1'b1;
    din  <= value;
    @(posedge clk);
    cs_n <= 1'b1;
    wr_n <= 1'b1;
    din  <= '0;
  endtask

  // dout is combinational, sampled mid cycle
  task host_read(input logic sel_n, input logic addr, output data_t value);
    @(posedge clk);
    cs_n <= sel_n;
    wr_n <= 1'b1;
    a0   <= addr;
    @(negedge clk);
    value = dout;
  endtask

  task automatic wait_status(input data_t expected, input int max_cycles,
                             input logic irq_stays_high);
    data_t value;
    int    waited;
    logic  done;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      host_read(1'b0, 1'b0, value);
      if (irq_stays_high) begin
        assert (irq_n === 1'b1) else report_mismatch("irq_n", 8'h01, irq_n);
      end
      if (value === expected) begin
        done = 1'b1;
      end else if (waited >= max_cycles) begin
        $display("status byte did not reach 0x%02h within %0d cycles", expected, max_cycles);
        stop_with_failure();
      end
      waited = waited + 1;
    end
  endtask

  // ---------------------------------------------------------
  // run limit
  // ---------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // ---------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------
  initial begin
    data_t t1_preset;
    data_t t2_preset;
    data_t value;
    int    t1_period;
    int    t2_period;
    rst         = 1'b1;
    cs_n        = 1'b1;
    wr_n        = 1'b1;
    a0          = 1'b0;
    din         = '0;
    lfsr_state  = 32'h49a1;
    cycle_count = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // idle after reset, unselected and a0 high reads give zero
    host_read(1'b0, 1'b0, value);
    assert (irq_n === 1'b1) else report_mismatch("irq_n", 8'h01, irq_n);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
    host_read(1'b1, 1'b0, value);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
    host_read(1'b0, 1'b1, value);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);

    // timer 1 started, unmasked
    draw_preset(t1_preset);
    t1_period = timer_period(t1_preset, T1_TICK);
    host_write(8'h02, t1_preset);
    host_write(8'h04, 8'h01);
    wait_status(STAT_T1, t1_period + 3, 1'b0);
    assert (irq_n === 1'b0) else report_mismatch("irq_n", 8'h00, irq_n);

    // unselected and a0 high reads with a flag set
    // these two cycles also keep the clear off the next timer 1 pulse
    host_read(1'b1, 1'b0, value);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
    host_read(1'b0, 1'b1, value);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
    host_write(8'h04, 8'h80);
    host_read(1'b0, 1'b0, value);
    assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
    assert (irq_n === 1'b1) else report_mismatch("irq_n", 8'h01, irq_n);
    wait_status(STAT_T1, t1_period, 1'b0);
    assert (irq_n === 1'b0) else report_mismatch("irq_n", 8'h00, irq_n);

    // timer 2 alone and masked, timer 1 stopped
    draw_preset(t2_preset);
    t2_period = timer_period(t2_preset, T2_TICK);
    host_write(8'h03, t2_preset);
    host_write(8'h04, 8'h22);
    host_write(8'h04, 8'h80);
    wait_status(STAT_T2, t2_period, 1'b1);
    assert (irq_n === 1'b1) else report_mismatch("irq_n", 8'h01, irq_n);

    // both stopped, nothing may come back
    host_write(8'h04, 8'h00);
    host_write(8'h04, 8'h80);
    for (int i = 0; i < 2 * t2_period; i++) begin
      host_read(1'b0, 1'b0, value);
      assert (value === 8'h00) else report_mismatch("dout", 8'h00, value);
      assert (irq_n === 1'b1) else report_mismatch("irq_n", 8'h01, irq_n);
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/opl_pkg.sv
src/opl_reg_if.sv
src/opl_bus_port.sv
src/opl_timer_regs.sv
src/opl_interval_timer.sv
src/opl_timers.sv
verification/opl_timers_assert.sv
verification/opl_timers_tb.sv
